// File: tb.f
sf_pkg.sv
sf_dip_regs.sv
sf_core_reset.sv
sf_control_map.sv
sf_video_out.sv
sf_shell_top.sv
tb_sf_shell.sv

// File: tb_sf_shell.sv
// testbench for the arcade shell top level
// config registers, manual reset, download gate, controls, video
// reference values built from the shell rules and lcg stimulus
module tb_sf_shell import sf_pkg::*; ();

    localparam int unsigned HOLD_CYCLES = 20;
    localparam int unsigned COIN_CYCLES = 12;

    logic         clk_74a;
    logic         rst_n;
    bridge_addr_t bridge_addr;
    logic         bridge_wr;
    bridge_data_t bridge_wr_data;
    bridge_data_t bridge_rd_data;
    logic         download_start;
    logic         download_done;
    logic         rom_wr;
    key_map_t     cont1_key;
    rgb12_t       game_rgb;
    logic         game_hblank;
    logic         game_vblank;
    logic         game_hs;
    logic         game_vs;
    dip_word_t    dip_sw;
    logic         core_reset;
    logic         rom_wr_en;
    controls_t    controls;
    rgb24_t       video_rgb;
    logic         video_de;
    logic         video_hs;
    logic         video_vs;

    // expected registered outputs one cycle behind the inputs
    logic         checks_on;
    logic         exp_de;
    rgb24_t       exp_rgb;
    logic         exp_hs;
    logic         exp_vs;
    logic         hs_prev;
    logic         vs_prev;
    logic [5:0]   exp_ctl;

    logic [31:0]  seed;
    logic [31:0]  rnd;
    lives_t       lives_e;
    difficulty_t  diff_e;
    bonus_t       bonus_e;
    logic         demo_e;
    logic         win_exp;
    int           high;
    int           round;
    int           i;

    sf_shell_top #(
        .RESET_HOLD     (HOLD_CYCLES),
        .COIN_PULSE_LEN (COIN_CYCLES)
    ) sf_shell_top_i (.*);

    always #5 clk_74a = ~clk_74a;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // upper halves only since low lcg bits cycle too fast
    task automatic random_word(output logic [31:0] value);
        seed = lcg_next(seed);
        value[31:16] = seed[31:16];
        seed = lcg_next(seed);
        value[15:0] = seed[31:16];
    endtask

    function automatic dip_word_t pack_dip(input lives_t l, input difficulty_t d,
                                           input bonus_t b, input logic s);
        return {2'b00, d, b, s, 1'b0, l, 4'b0000};
    endfunction

    // up, down, left, right, fire, start
    function automatic logic [5:0] map_keys(input key_map_t k);
        return {k[KEY_UP], k[KEY_DOWN], k[KEY_LEFT], k[KEY_RIGHT], k[KEY_FIRE], k[KEY_START]};
    endfunction

    // each nibble repeated into its byte
    function automatic rgb24_t expand_colour(input rgb12_t c);
        return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            stop_with_error($sformatf("** Error %s expected %h actual %h",
                                      name, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(negedge clk_74a);
    endtask

    // one-cycle write strobe that returns on the next falling edge
    task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        next_cycle();
        bridge_wr      = 1'b0;
    endtask

    // read path is combinational
    task automatic check_read(input bridge_addr_t addr, input bridge_data_t expected);
        bridge_addr = addr;
        #1;
        check_value("bridge_rd_data", expected, bridge_rd_data);
        next_cycle();
    endtask

    ////////////////////////////////////////
    // registered output reference
    ////////////////////////////////////////

    always @(posedge clk_74a) begin
        if (!rst_n) begin
            exp_de  <= 1'b0;
            exp_rgb <= '0;
            exp_hs  <= 1'b0;
            exp_vs  <= 1'b0;
            hs_prev <= 1'b0;
            vs_prev <= 1'b0;
            exp_ctl <= '0;
        end else begin
            exp_de  <= !game_hblank && !game_vblank;
            exp_rgb <= (!game_hblank && !game_vblank) ? expand_colour(game_rgb) : '0;
            // pulse on the first high after a low
            exp_hs  <= game_hs && !hs_prev;
            exp_vs  <= game_vs && !vs_prev;
            hs_prev <= game_hs;
            vs_prev <= game_vs;
            exp_ctl <= map_keys(cont1_key);
        end
    end

    assert property (@(posedge clk_74a) disable iff (!checks_on) video_de == exp_de)
        else stop_with_error($sformatf("** Error video_de expected %h actual %h",
                                       $sampled(exp_de), $sampled(video_de)));
    assert property (@(posedge clk_74a) disable iff (!checks_on) video_rgb == exp_rgb)
        else stop_with_error($sformatf("** Error video_rgb expected %h actual %h",
                                       $sampled(exp_rgb), $sampled(video_rgb)));
    assert property (@(posedge clk_74a) disable iff (!checks_on) video_hs == exp_hs)
        else stop_with_error($sformatf("** Error video_hs expected %h actual %h",
                                       $sampled(exp_hs), $sampled(video_hs)));
    assert property (@(posedge clk_74a) disable iff (!checks_on) video_vs == exp_vs)
        else stop_with_error($sformatf("** Error video_vs expected %h actual %h",
                                       $sampled(exp_vs), $sampled(video_vs)));
    assert property (@(posedge clk_74a) disable iff (!checks_on) video_hs |=> !video_hs)
        else stop_with_error("video_hs stayed high for more than one cycle");
    assert property (@(posedge clk_74a) disable iff (!checks_on) video_vs |=> !video_vs)
        else stop_with_error("video_vs stayed high for more than one cycle");
    assert property (@(posedge clk_74a) disable iff (!checks_on) controls[6:1] == exp_ctl)
        else stop_with_error($sformatf("** Error controls[6:1] expected %h actual %h",
                                       $sampled(exp_ctl), $sampled(controls[6:1])));

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        clk_74a        = 1'b0;
        rst_n          = 1'b0;
        bridge_addr    = '0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        download_start = 1'b0;
        download_done  = 1'b0;
        rom_wr         = 1'b0;
        cont1_key      = '0;
        game_rgb       = '0;
        game_hblank    = 1'b0;
        game_vblank    = 1'b0;
        game_hs        = 1'b0;
        game_vs        = 1'b0;
        checks_on      = 1'b0;
        seed           = 32'd52868;
        win_exp        = 1'b0;
        lives_e        = '0;
        diff_e         = '0;
        bonus_e        = '0;
        demo_e         = 1'b0;

        repeat (10) next_cycle();
        rst_n = 1'b1;
        // nothing else holds the core once the board reset lifts
        #1;
        check_value("core_reset", 32'h0, core_reset);
        next_cycle();
        checks_on = 1'b1;

        // configuration writes and read-back
        for (round = 0; round < 4; round++) begin
            random_word(rnd);
            bridge_write(ADDR_LIVES, rnd);
            lives_e = rnd[LIVES_W-1:0];
            check_value("dip_sw", pack_dip(lives_e, diff_e, bonus_e, demo_e), dip_sw);
            random_word(rnd);
            bridge_write(ADDR_DIFFICULTY, rnd);
            diff_e = rnd[DIFFICULTY_W-1:0];
            check_value("dip_sw", pack_dip(lives_e, diff_e, bonus_e, demo_e), dip_sw);
            random_word(rnd);
            bridge_write(ADDR_BONUS, rnd);
            bonus_e = rnd[BONUS_W-1:0];
            check_value("dip_sw", pack_dip(lives_e, diff_e, bonus_e, demo_e), dip_sw);
            random_word(rnd);
            bridge_write(ADDR_DEMO_SOUNDS, rnd);
            demo_e = rnd[0];
            check_value("dip_sw", pack_dip(lives_e, diff_e, bonus_e, demo_e), dip_sw);
            check_read(ADDR_LIVES, 32'(lives_e));
            check_read(ADDR_DIFFICULTY, 32'(diff_e));
            check_read(ADDR_BONUS, 32'(bonus_e));
            check_read(ADDR_DEMO_SOUNDS, 32'(demo_e));
            // odd addresses never hit the map
            random_word(rnd);
            check_read(rnd | 32'h1, 32'h0);
            check_read(ADDR_RESET_TOGGLE, 32'h0);
        end

        // manual reset with a second request mid-pulse
        bridge_write(ADDR_RESET_TOGGLE, 32'h1);
        // toggle level now high yet the address still reads zero
        check_value("bridge_rd_data", 32'h0, bridge_rd_data);
        check_value("core_reset", 32'h0, core_reset);
        next_cycle();
        check_value("core_reset", 32'h1, core_reset);
        high = 0;
        while (core_reset === 1'b1) begin
            high++;
            if (high > 100) begin
                stop_with_error("manual reset pulse did not end within 100 cycles");
            end
            bridge_wr = (high == 6);
            next_cycle();
        end
        bridge_wr = 1'b0;
        check_value("manual reset length", HOLD_CYCLES, high);
        for (i = 0; i < 8; i++) begin
            check_value("core_reset", 32'h0, core_reset);
            next_cycle();
        end

        // download window with start and done in one cycle at step 26
        for (i = 0; i < 40; i++) begin
            // window follows the strobes taken at the last edge
            if (download_start) begin
                win_exp = 1'b1;
            end else if (download_done) begin
                win_exp = 1'b0;
            end
            random_word(rnd);
            rom_wr         = rnd[0];
            download_start = (i == 4) || (i == 26);
            download_done  = (i == 20) || (i == 26) || (i == 32);
            #1;
            check_value("rom_wr_en", rom_wr && win_exp, rom_wr_en);
            check_value("core_reset", win_exp, core_reset);
            next_cycle();
        end
        rom_wr = 1'b0;

        // random keys with coin held off
        for (i = 0; i < 60; i++) begin
            random_word(rnd);
            cont1_key = rnd[15:0];
            cont1_key[KEY_COIN] = 1'b0;
            next_cycle();
        end
        cont1_key = '0;
        next_cycle();

        // coin press and release
        cont1_key[KEY_COIN] = 1'b1;
        next_cycle();
        cont1_key[KEY_COIN] = 1'b0;
        next_cycle();
        check_value("controls[0]", 32'h0, controls[CTL_COIN]);
        next_cycle();
        check_value("controls[0]", 32'h1, controls[CTL_COIN]);
        high = 0;
        while (controls[CTL_COIN] === 1'b1) begin
            high++;
            if (high > 100) begin
                stop_with_error("coin pulse did not end within 100 cycles");
            end
            // press and release inside the pulse
            cont1_key[KEY_COIN] = (high == 3);
            next_cycle();
        end
        check_value("coin pulse length", COIN_CYCLES, high);
        for (i = 0; i < 20; i++) begin
            check_value("controls[0]", 32'h0, controls[CTL_COIN]);
            next_cycle();
        end

        // random colour, blanking and sync levels
        for (i = 0; i < 300; i++) begin
            random_word(rnd);
            game_rgb    = rnd[11:0];
            game_hblank = &rnd[13:12];
            game_vblank = &rnd[15:14];
            game_hs     = rnd[16];
            game_vs     = rnd[17];
            next_cycle();
        end
        game_hs = 1'b0;
        game_vs = 1'b0;
        next_cycle();
        next_cycle();

        $display("Regression passed");
        $finish;
    end

endmodule

// File: sf_shell_top.sv
// board-facing shell top level
// config registers, core reset, controls and video output
module sf_shell_top import sf_pkg::*; #(
    parameter int unsigned RESET_HOLD     = 4194303,
    parameter int unsigned COIN_PULSE_LEN = 1048575
) (
    input  logic         clk_74a,
    input  logic         rst_n,

    // host bridge
    input  bridge_addr_t bridge_addr,
    input  logic         bridge_wr,
    input  bridge_data_t bridge_wr_data,
    output bridge_data_t bridge_rd_data,

    // rom download
    input  logic         download_start,
    input  logic         download_done,
    input  logic         rom_wr,

    // player one controller
    input  key_map_t     cont1_key,

    // game video in
    input  rgb12_t       game_rgb,
    input  logic         game_hblank,
    input  logic         game_vblank,
    input  logic         game_hs,
    input  logic         game_vs,

    // to the game core
    output dip_word_t    dip_sw,
    output logic         core_reset,
    output logic         rom_wr_en,
    output controls_t    controls,

    // to the scaler
    output rgb24_t       video_rgb,
    output logic         video_de,
    output logic         video_hs,
    output logic         video_vs
);

    // flips on each host reset request
    logic reset_toggle;

    ////////////////////////////////////////
    // configuration
    ////////////////////////////////////////

    sf_dip_regs sf_dip_regs_i (
        .clk_74a        (clk_74a),
        .rst_n          (rst_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .dip_sw         (dip_sw),
        .reset_toggle   (reset_toggle)
    );

    ////////////////////////////////////////
    // reset and rom gate
    ////////////////////////////////////////

    sf_core_reset #(
        .RESET_HOLD (RESET_HOLD)
    ) sf_core_reset_i (
        .clk_74a        (clk_74a),
        .rst_n          (rst_n),
        .reset_toggle   (reset_toggle),
        .download_start (download_start),
        .download_done  (download_done),
        .rom_wr         (rom_wr),
        .core_reset     (core_reset),
        .rom_wr_en      (rom_wr_en)
    );

    ////////////////////////////////////////
    // controls
    ////////////////////////////////////////

    sf_control_map #(
        .COIN_PULSE_LEN (COIN_PULSE_LEN)
    ) sf_control_map_i (
        .clk_74a   (clk_74a),
        .rst_n     (rst_n),
        .cont1_key (cont1_key),
        .controls  (controls)
    );

    ////////////////////////////////////////
    // video
    ////////////////////////////////////////

    sf_video_out sf_video_out_i (
        .clk_74a     (clk_74a),
        .rst_n       (rst_n),
        .game_rgb    (game_rgb),
        .game_hblank (game_hblank),
        .game_vblank (game_vblank),
        .game_hs     (game_hs),
        .game_vs     (game_vs),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs)
    );

endmodule

// File: sf_video_out.sv
// video output stage
// 12 to 24 bit colour, data enable, sync edge pulses
module sf_video_out import sf_pkg::*; (
    input  logic   clk_74a,
    input  logic   rst_n,
    input  rgb12_t game_rgb,
    input  logic   game_hblank,
    input  logic   game_vblank,
    input  logic   game_hs,
    input  logic   game_vs,
    output rgb24_t video_rgb,
    output logic   video_de,
    output logic   video_hs,
    output logic   video_vs
);

    // bit 1 vsync, bit 0 hsync
    logic [1:0] sync_in;
    logic [1:0] sync_prev;
    logic       active;

    assign sync_in = {game_vs, game_hs};
    assign active  = !game_hblank && !game_vblank;

    ////////////////////////////////////////
    // colour and enable
    ////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            video_rgb <= '0;
            video_de  <= 1'b0;
        end else if (active) begin
            video_de <= 1'b1;
            // nibble repeated fills the byte evenly
            video_rgb <= {
                {2{game_rgb[11:8]}},
                {2{game_rgb[7:4]}},
                {2{game_rgb[3:0]}}
            };
        end else begin
            // black during blanking
            video_rgb <= '0;
            video_de  <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // sync pulses
    ////////////////////////////////////////

    // one-cycle pulse on each rising sync edge
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            sync_prev <= '0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
        end else begin
            sync_prev <= sync_in;
            video_hs  <= sync_in[0] && !sync_prev[0];
            video_vs  <= sync_in[1] && !sync_prev[1];
        end
    end

endmodule

// File: sf_control_map.sv
// player one control mapping
// key bitmap to game order, coin release stretched to a pulse
module sf_control_map import sf_pkg::*; #(
    parameter int unsigned COIN_PULSE_LEN = 1048575
) (
    input  logic      clk_74a,
    input  logic      rst_n,
    input  key_map_t  cont1_key,
    output controls_t controls
);

    localparam int CNT_W = $clog2(COIN_PULSE_LEN + 1);

    logic             coin_prev;
    logic [CNT_W-1:0] coin_cnt;
    logic             coin_idle;

    // no pulse pending and none on the output
    assign coin_idle = (coin_cnt == '0) && !controls[CTL_COIN];

    ////////////////////////////////////////
    // coin pulse
    ////////////////////////////////////////

    // release loads the counter, the output bit follows a cycle later
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            coin_prev <= 1'b0;
            coin_cnt  <= '0;
        end else if (coin_idle) begin
            coin_prev <= cont1_key[KEY_COIN];
            // key went 1 then 0
            if (coin_prev && !cont1_key[KEY_COIN]) begin
                coin_cnt <= CNT_W'(COIN_PULSE_LEN);
            end
        end else if (coin_cnt != '0) begin
            coin_cnt <= coin_cnt - 1'b1;
        end
    end

    ////////////////////////////////////////
    // control vector
    ////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            controls <= '0;
        end else begin
            controls[CTL_UP]    <= cont1_key[KEY_UP];
            controls[CTL_DOWN]  <= cont1_key[KEY_DOWN];
            controls[CTL_LEFT]  <= cont1_key[KEY_LEFT];
            controls[CTL_RIGHT] <= cont1_key[KEY_RIGHT];
            controls[CTL_FIRE]  <= cont1_key[KEY_FIRE];
            controls[CTL_START] <= cont1_key[KEY_START];
            // high for one cycle per count
            controls[CTL_COIN]  <= (coin_cnt != '0);
        end
    end

endmodule

// File: sf_core_reset.sv
// core reset generation
// manual reset stretcher, download window, rom write gate
module sf_core_reset import sf_pkg::*; #(
    parameter int unsigned RESET_HOLD = 4194303
) (
    input  logic clk_74a,
    input  logic rst_n,
    input  logic reset_toggle,
    input  logic download_start,
    input  logic download_done,
    input  logic rom_wr,
    output logic core_reset,
    output logic rom_wr_en
);

    // wide enough for RESET_HOLD - 1
    localparam int HOLD_W = $clog2(RESET_HOLD + 1);

    logic              toggle_prev;
    logic              manual_active;
    logic [HOLD_W-1:0] hold_cnt;
    logic              download_active;

    ////////////////////////////////////////
    // manual reset
    ////////////////////////////////////////

    // toggle change starts a fixed-length hold
    // changes seen mid-hold are absorbed by toggle_prev
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            toggle_prev   <= 1'b0;
            manual_active <= 1'b0;
            hold_cnt      <= '0;
        end else begin
            toggle_prev <= reset_toggle;
            if (!manual_active) begin
                if (reset_toggle != toggle_prev) begin
                    manual_active <= 1'b1;
                    hold_cnt      <= HOLD_W'(RESET_HOLD - 1);
                end
            end else if (hold_cnt == '0) begin
                // last cycle of the hold
                manual_active <= 1'b0;
            end else begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // download window
    ////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            download_active <= 1'b0;
        end else if (download_start) begin
            // start wins over a same-cycle done
            download_active <= 1'b1;
        end else if (download_done) begin
            download_active <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////

    // core held while any source is active
    assign core_reset = !rst_n || download_active || manual_active;

    // rom writes only land inside the window
    assign rom_wr_en = rom_wr && download_active;

endmodule

// File: sf_dip_regs.sv
// host configuration registers
// dip word packing, bridge read-back, reset toggle level
module sf_dip_regs import sf_pkg::*; (
    input  logic         clk_74a,
    input  logic         rst_n,
    input  bridge_addr_t bridge_addr,
    input  logic         bridge_wr,
    input  bridge_data_t bridge_wr_data,
    output bridge_data_t bridge_rd_data,
    output dip_word_t    dip_sw,
    output logic         reset_toggle
);

    lives_t      lives_q;
    difficulty_t difficulty_q;
    bonus_t      bonus_q;
    logic        demo_sounds_q;

    ////////////////////////////////////////
    // write decode
    ////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            lives_q       <= '0;
            difficulty_q  <= '0;
            bonus_q       <= '0;
            demo_sounds_q <= 1'b0;
            reset_toggle  <= 1'b0;
        end else if (bridge_wr) begin
            // low bits of the data word only
            case (bridge_addr)
                ADDR_LIVES: begin
                    lives_q <= bridge_wr_data[LIVES_W-1:0];
                end
                ADDR_DIFFICULTY: begin
                    difficulty_q <= bridge_wr_data[DIFFICULTY_W-1:0];
                end
                ADDR_BONUS: begin
                    bonus_q <= bridge_wr_data[BONUS_W-1:0];
                end
                ADDR_DEMO_SOUNDS: begin
                    demo_sounds_q <= bridge_wr_data[0];
                end
                ADDR_RESET_TOGGLE: begin
                    // level flip, edge found downstream
                    reset_toggle <= ~reset_toggle;
                end
                default: begin
                    // unmapped, write dropped
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // switch word
    ////////////////////////////////////////

    // 15:14 zero, 13:11 difficulty, 10:8 bonus
    // 7 demo sounds, 6 zero, 5:4 lives, 3:0 zero
    assign dip_sw = {
        2'b00,
        difficulty_q,
        bonus_q,
        demo_sounds_q,
        1'b0,
        lives_q,
        4'b0000
    };

    ////////////////////////////////////////
    // read-back
    ////////////////////////////////////////

    always_comb begin
        bridge_rd_data = '0;
        case (bridge_addr)
            ADDR_LIVES:       bridge_rd_data = bridge_data_t'(lives_q);
            ADDR_DIFFICULTY:  bridge_rd_data = bridge_data_t'(difficulty_q);
            ADDR_BONUS:       bridge_rd_data = bridge_data_t'(bonus_q);
            ADDR_DEMO_SOUNDS: bridge_rd_data = bridge_data_t'(demo_sounds_q);
            // toggle address reads as zero too
            default:          bridge_rd_data = '0;
        endcase
    end

endmodule

// File: sf_pkg.sv
// shared definitions for the arcade shell
// bridge address map, setting field widths,
// key bitmap and control vector bit positions
package sf_pkg;

    ////////////////////////////////////////
    // bridge bus
    ////////////////////////////////////////

    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    // setting registers, one word each
    localparam bridge_addr_t ADDR_LIVES        = 32'h2000_0000;
    localparam bridge_addr_t ADDR_DIFFICULTY   = 32'h3000_0000;
    localparam bridge_addr_t ADDR_BONUS        = 32'h4000_0000;
    localparam bridge_addr_t ADDR_DEMO_SOUNDS  = 32'h5000_0000;
    // any write here flips the manual reset level
    localparam bridge_addr_t ADDR_RESET_TOGGLE = 32'h8000_0000;

    ////////////////////////////////////////
    // dip switch settings
    ////////////////////////////////////////

    localparam int LIVES_W      = 2;
    localparam int DIFFICULTY_W = 3;
    localparam int BONUS_W      = 3;

    typedef logic [LIVES_W-1:0]      lives_t;
    typedef logic [DIFFICULTY_W-1:0] difficulty_t;
    typedef logic [BONUS_W-1:0]      bonus_t;

    // switch word in game order
    typedef logic [15:0] dip_word_t;

    ////////////////////////////////////////
    // controls
    ////////////////////////////////////////

    typedef logic [15:0] key_map_t;
    typedef logic [6:0]  controls_t;

    // controller key bitmap positions
    localparam int KEY_UP    = 0;
    localparam int KEY_DOWN  = 1;
    localparam int KEY_LEFT  = 2;
    localparam int KEY_RIGHT = 3;
    localparam int KEY_FIRE  = 4;
    localparam int KEY_COIN  = 14;
    localparam int KEY_START = 15;

    // game control vector positions
    localparam int CTL_UP    = 6;
    localparam int CTL_DOWN  = 5;
    localparam int CTL_LEFT  = 4;
    localparam int CTL_RIGHT = 3;
    localparam int CTL_FIRE  = 2;
    localparam int CTL_START = 1;
    localparam int CTL_COIN  = 0;

    ////////////////////////////////////////
    // video
    ////////////////////////////////////////

    // red in the top field for both
    typedef logic [11:0] rgb12_t;
    typedef logic [23:0] rgb24_t;

endpackage
